// File: apb_uart.sv
`timescale 1ns/10ps
`include "uart_apb_macros.svh"

module apb_uart
    import uart_apb_pkg::*;
#(
    parameter int tick_div = `UART_TICK_DIV_DEFAULT
) (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  logic     rx,
    output logic     tx
);

    uart_status_t status;
    uart_byte_t   tx_wdata;
    uart_byte_t   tx_head;
    uart_byte_t   rx_rdata;
    uart_byte_t   rx_byte;
    logic         tx_push;
    logic         rx_pop;
    logic         tick;
    logic         take;
    logic         rx_done;
    logic         tx_full;
    logic         tx_empty;
    logic         rx_full;
    logic         rx_empty;

    // status word from the fifo flags
    assign status = '{
        rx_full:  rx_full,
        tx_empty: tx_empty,
        tx_full:  tx_full,
        rx_empty: rx_empty
    };

    apb_uart_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .status   (status),
        .rx_rdata (rx_rdata),
        .tx_wdata (tx_wdata),
        .tx_push  (tx_push),
        .rx_pop   (rx_pop)
    );

    baud_tick_gen #(
        .tick_div (tick_div)
    ) u_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    byte_fifo #(
        .addr_w (`UART_FIFO_AW)
    ) u_tx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (tx_push),
        .pop   (take),
        .wdata (tx_wdata),
        .rdata (tx_head),
        .full  (tx_full),
        .empty (tx_empty)
    );

    byte_fifo #(
        .addr_w (`UART_FIFO_AW)
    ) u_rx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rx_done),
        .pop   (rx_pop),
        .wdata (rx_byte),
        .rdata (rx_rdata),
        .full  (rx_full),
        .empty (rx_empty)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .tx_valid (!tx_empty),
        .tx_data  (tx_head),
        .take     (take),
        .tx       (tx)
    );

    uart_rx u_rx (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .rx      (rx),
        .rx_data (rx_byte),
        .rx_done (rx_done)
    );

endmodule

// File: apb_uart_regs.sv
`timescale 1ns/10ps
`include "uart_apb_macros.svh"

module apb_uart_regs
    import uart_apb_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  apb_req_t     apb_req,
    output apb_rsp_t     apb_rsp,
    input  uart_status_t status,
    input  uart_byte_t   rx_rdata,
    output uart_byte_t   tx_wdata,
    output logic         tx_push,
    output logic         rx_pop
);

    localparam int data_w = `APB_DATA_W;

    apb_state_e state_q, state_d;

    logic [data_w-1:0] rdata_q, rdata_d;
    uart_byte_t        wdata_q, wdata_d;
    logic              ready_q, ready_d;
    logic              push_q, push_d;
    logic              pop_q, pop_d;

    assign apb_rsp.rdata = rdata_q;
    assign apb_rsp.ready = ready_q;
    assign tx_wdata      = wdata_q;
    assign tx_push       = push_q;
    assign rx_pop        = pop_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= idle;
            ready_q <= 1'b0;
            push_q  <= 1'b0;
            pop_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            ready_q <= ready_d;
            push_q  <= push_d;
            pop_q   <= pop_d;
        end
    end

    // response data and tx byte
    always_ff @(posedge clk) begin
        rdata_q <= rdata_d;
        wdata_q <= wdata_d;
    end

    always_comb begin
        state_d = state_q;
        ready_d = 1'b0;
        push_d  = 1'b0;
        pop_d   = 1'b0;
        rdata_d = rdata_q;
        wdata_d = wdata_q;
        case (state_q)
            idle: begin
                if (apb_req.sel && apb_req.enable) begin
                    ready_d = 1'b1;
                    if (apb_req.write) begin
                        state_d = write;
                        // only txdata takes writes
                        if (apb_req.addr == `UART_REG_TXDATA) begin
                            push_d  = 1'b1;
                            wdata_d = apb_req.wdata[`UART_DATA_W-1:0];
                        end
                    end else begin
                        state_d = read;
                        case (apb_req.addr)
                            `UART_REG_STATUS: rdata_d = data_w'(status);
                            `UART_REG_RXDATA: begin
                                rdata_d = data_w'(rx_rdata);
                                pop_d   = 1'b1;
                            end
                            default: rdata_d = '0;
                        endcase
                    end
                end
            end
            read, write: begin
                state_d = idle;
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    // a single access drives at most one fifo strobe
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(tx_push && rx_pop));

endmodule

// File: baud_tick_gen.sv
`timescale 1ns/10ps
`include "uart_apb_macros.svh"

module baud_tick_gen #(
    parameter int tick_div = `UART_TICK_DIV_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int cnt_w = $clog2(tick_div);
    localparam logic [cnt_w-1:0] reload = cnt_w'(tick_div - 1);

    logic [cnt_w-1:0] cnt_q;
    logic             tick_q;

    assign tick = tick_q;

    // down-counter, tick on terminal count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q  <= reload;
            tick_q <= 1'b0;
        end else if (cnt_q == '0) begin
            cnt_q  <= reload;
            tick_q <= 1'b1;
        end else begin
            cnt_q  <= cnt_q - 1'b1;
            tick_q <= 1'b0;
        end
    end

    a_tick_single: assert property (@(posedge clk) disable iff (rst)
        tick |=> !tick);

endmodule

// File: byte_fifo.sv
`timescale 1ns/10ps
`include "uart_apb_macros.svh"

module byte_fifo
    import uart_apb_pkg::*;
#(
    parameter int addr_w = `UART_FIFO_AW
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic       pop,
    input  uart_byte_t wdata,
    output uart_byte_t rdata,
    output logic       full,
    output logic       empty
);

    uart_byte_t mem [2**addr_w];

    logic [addr_w-1:0] wr_q, wr_d;
    logic [addr_w-1:0] rd_q, rd_d;
    logic              full_q, full_d;
    logic              empty_q, empty_d;
    logic              wr_en;

    assign rdata = mem[rd_q];
    assign full  = full_q;
    assign empty = empty_q;
    assign wr_en = push && !full_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_q] <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_q    <= '0;
            rd_q    <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            wr_q    <= wr_d;
            rd_q    <= rd_d;
            full_q  <= full_d;
            empty_q <= empty_d;
        end
    end

    always_comb begin
        wr_d    = wr_q;
        rd_d    = rd_q;
        full_d  = full_q;
        empty_d = empty_q;
        case ({push, pop})
            2'b01: begin
                if (!empty_q) begin
                    rd_d    = rd_q + 1'b1;
                    full_d  = 1'b0;
                    empty_d = (rd_d == wr_q);
                end
            end
            2'b10: begin
                if (!full_q) begin
                    wr_d    = wr_q + 1'b1;
                    empty_d = 1'b0;
                    full_d  = (wr_d == rd_q);
                end
            end
            2'b11: begin
                // full drops the push, empty drops the pop
                if (full_q) begin
                    rd_d   = rd_q + 1'b1;
                    full_d = 1'b0;
                end else if (empty_q) begin
                    wr_d    = wr_q + 1'b1;
                    empty_d = 1'b0;
                end else begin
                    rd_d = rd_q + 1'b1;
                    wr_d = wr_q + 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    a_flags_excl: assert property (@(posedge clk) disable iff (rst)
        !(full && empty));

endmodule

// File: sources.f
+incdir+.
uart_apb_pkg.sv
apb_uart_regs.sv
baud_tick_gen.sv
byte_fifo.sv
uart_tx.sv
uart_rx.sv
apb_uart.sv
tb_apb_uart.sv

// File: tb_apb_uart.sv
`timescale 1ns/10ps
`include "uart_apb_macros.svh"

module tb_apb_uart
    import uart_apb_pkg::*;
();

    localparam int tick_div    = 4;
    localparam int clk_period  = 40;
    localparam int bit_clks    = tick_div * `UART_OVERSAMPLE;
    localparam int frame_clks  = bit_clks * 10;
    localparam int watchdog_ns = 40 * frame_clks * clk_period + 100000;

    logic        clk;
    logic        rst;
    logic        rx;
    logic        tx;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] lcg_state;
    uart_byte_t  sent_q[$];
    uart_byte_t  got_q[$];

    apb_uart #(
        .tick_div (tick_div)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .rx      (rx),
        .tx      (tx)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: tests did not finish within %0d ns", watchdog_ns);
        stop_with_failure();
    end

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_status(input string name, input uart_status_t got,
                                input uart_status_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%01h expected 0x%01h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%01h expected 0x%01h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // 32-bit lcg, byte taken from the middle bits
    function automatic uart_byte_t next_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic uart_status_t status_of(input logic rx_full, input logic tx_empty,
                                               input logic tx_full, input logic rx_empty);
        uart_status_t st;
        st.rx_full  = rx_full;
        st.tx_empty = tx_empty;
        st.tx_full  = tx_full;
        st.rx_empty = rx_empty;
        return st;
    endfunction

    // setup phase, then access phase held until ready
    task automatic apb_access(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [`APB_DATA_W-1:0] wdata,
                              output logic [`APB_DATA_W-1:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        apb_req.addr   = addr;
        apb_req.write  = write;
        apb_req.wdata  = wdata;
        apb_req.sel    = 1'b1;
        apb_req.enable = 1'b0;
        @(negedge clk);
        apb_req.enable = 1'b1;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 8) begin
                $display("apb access to address 0x%0h never got ready", addr);
                stop_with_failure();
            end
        end while (!apb_rsp.ready);
        rdata          = apb_rsp.rdata;
        apb_req.sel    = 1'b0;
        apb_req.enable = 1'b0;
    endtask

    task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr,
                             input logic [`APB_DATA_W-1:0] data);
        logic [`APB_DATA_W-1:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr,
                            output logic [`APB_DATA_W-1:0] data);
        apb_access(1'b0, addr, '0, data);
    endtask

    task automatic expect_status(input uart_status_t exp);
        logic [`APB_DATA_W-1:0] data;
        apb_read(`UART_REG_STATUS, data);
        if (data[`APB_DATA_W-1:4] !== '0) begin
            $display("status read has nonzero upper bits");
            stop_with_failure();
        end
        check_status("status", uart_status_t'(data[3:0]), exp);
    endtask

    task automatic expect_rxdata(input uart_byte_t exp);
        logic [`APB_DATA_W-1:0] data;
        apb_read(`UART_REG_RXDATA, data);
        check_byte("rxdata", data[`UART_DATA_W-1:0], exp);
    endtask

    // 8n1 frame on rx, lsb first
    task automatic serial_send(input uart_byte_t data);
        rx = 1'b0;
        repeat (bit_clks) @(negedge clk);
        for (int i = 0; i < `UART_DATA_W; i++) begin
            rx = data[i];
            repeat (bit_clks) @(negedge clk);
        end
        rx = 1'b1;
        repeat (bit_clks) @(negedge clk);
    endtask

    task automatic serial_recv(output uart_byte_t data);
        int waited;
        waited = 0;
        while (tx !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > 2 * frame_clks) begin
                $display("no start bit seen on tx");
                stop_with_failure();
            end
        end
        // middle of the start bit
        repeat (bit_clks / 2) @(negedge clk);
        check_level("tx start bit", tx, 1'b0);
        for (int i = 0; i < `UART_DATA_W; i++) begin
            repeat (bit_clks) @(negedge clk);
            data[i] = tx;
        end
        repeat (bit_clks) @(negedge clk);
        check_level("tx stop bit", tx, 1'b1);
    endtask

    task automatic test_reset_state();
        expect_status(status_of(1'b0, 1'b1, 1'b0, 1'b1));
        repeat (bit_clks) @(negedge clk);
        check_level("tx", tx, 1'b1);
    endtask

    task automatic test_single_tx();
        uart_byte_t b;
        uart_byte_t got;
        b = next_byte();
        apb_write(`UART_REG_TXDATA, `APB_DATA_W'(b));
        serial_recv(got);
        check_byte("tx frame", got, b);
    endtask

    task automatic test_single_rx();
        uart_byte_t b;
        b = next_byte();
        serial_send(b);
        repeat (bit_clks) @(negedge clk);
        expect_status(status_of(1'b0, 1'b1, 1'b0, 1'b0));
        expect_rxdata(b);
        expect_status(status_of(1'b0, 1'b1, 1'b0, 1'b1));
    endtask

    task automatic test_tx_fifo_fill();
        uart_byte_t got;
        sent_q.delete();
        got_q.delete();
        for (int i = 0; i < 9; i++) begin
            sent_q.push_back(next_byte());
        end
        fork
            begin
                foreach (sent_q[i]) begin
                    apb_write(`UART_REG_TXDATA, `APB_DATA_W'(sent_q[i]));
                end
                // one byte in the transmitter, eight queued
                expect_status(status_of(1'b0, 1'b0, 1'b1, 1'b1));
            end
            begin
                repeat (9) begin
                    serial_recv(got);
                    got_q.push_back(got);
                end
            end
        join
        foreach (sent_q[i]) begin
            check_byte("tx frame", got_q[i], sent_q[i]);
        end
        expect_status(status_of(1'b0, 1'b1, 1'b0, 1'b1));
    endtask

    task automatic test_rx_overflow();
        sent_q.delete();
        for (int i = 0; i < 9; i++) begin
            sent_q.push_back(next_byte());
            serial_send(sent_q[i]);
        end
        repeat (bit_clks) @(negedge clk);
        expect_status(status_of(1'b1, 1'b1, 1'b0, 1'b0));
        // ninth byte was dropped
        for (int i = 0; i < 8; i++) begin
            expect_rxdata(sent_q[i]);
        end
        expect_status(status_of(1'b0, 1'b1, 1'b0, 1'b1));
    endtask

    initial begin
        lcg_state = 32'd3;
        rst       = 1'b1;
        rx        = 1'b1;
        apb_req   = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_single_tx();
        test_single_rx();
        test_tx_fifo_fill();
        test_rx_overflow();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: uart_apb_macros.svh
`ifndef UART_APB_MACROS_SVH
`define UART_APB_MACROS_SVH

// serial frame
`define UART_DATA_W 8
`define UART_OVERSAMPLE 16

// fifo depth is 2**aw
`define UART_FIFO_AW 3

// 100 MHz clock, 9600 baud x 16
`define UART_TICK_DIV_DEFAULT 651

// apb bus widths
`define APB_ADDR_W 4
`define APB_DATA_W 32

// register offsets
`define UART_REG_STATUS 4'h0
`define UART_REG_TXDATA 4'h4
`define UART_REG_RXDATA 4'h8

`endif

// File: uart_apb_pkg.sv
`include "uart_apb_macros.svh"

package uart_apb_pkg;

    // one frame payload
    typedef logic [`UART_DATA_W-1:0] uart_byte_t;

    // master side of the bus
    typedef struct packed {
        logic [`APB_ADDR_W-1:0] addr;
        logic                   write;
        logic                   sel;
        logic                   enable;
        logic [`APB_DATA_W-1:0] wdata;
    } apb_req_t;

    // slave side of the bus
    typedef struct packed {
        logic [`APB_DATA_W-1:0] rdata;
        logic                   ready;
    } apb_rsp_t;

    // fifo flags as seen in the status word
    typedef struct packed {
        logic rx_full;
        logic tx_empty;
        logic tx_full;
        logic rx_empty;
    } uart_status_t;

    typedef enum logic [1:0] {
        idle,
        read,
        write
    } apb_state_e;

endpackage

// File: uart_rx.sv
`timescale 1ns/10ps
`include "uart_apb_macros.svh"

module uart_rx
    import uart_apb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       rx,
    output uart_byte_t rx_data,
    output logic       rx_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_e;

    rx_state_e  state_q, state_d;
    logic [3:0] tick_q, tick_d;
    logic [2:0] bit_q, bit_d;
    uart_byte_t buf_q, buf_d;
    logic       done_d;
    logic       rx_meta;
    logic       rx_sync;

    assign rx_data = buf_q;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_idle;
            tick_q  <= '0;
            bit_q   <= '0;
            rx_done <= 1'b0;
        end else begin
            state_q <= state_d;
            tick_q  <= tick_d;
            bit_q   <= bit_d;
            rx_done <= done_d;
        end
    end

    always_ff @(posedge clk) begin
        buf_q <= buf_d;
    end

    always_comb begin
        state_d = state_q;
        tick_d  = tick_q;
        bit_d   = bit_q;
        buf_d   = buf_q;
        done_d  = 1'b0;
        case (state_q)
            st_idle: begin
                if (!rx_sync) begin
                    tick_d  = '0;
                    state_d = st_start;
                end
            end
            st_start: begin
                // half a bit to the middle of start
                if (tick) begin
                    tick_d = tick_q + 1'b1;
                    if (tick_q == 4'(`UART_OVERSAMPLE / 2 - 1)) begin
                        tick_d  = '0;
                        bit_d   = '0;
                        state_d = rx_sync ? st_idle : st_data;
                    end
                end
            end
            st_data: begin
                if (tick) begin
                    tick_d = tick_q + 1'b1;
                    if (tick_q == 4'(`UART_OVERSAMPLE - 1)) begin
                        buf_d = {rx_sync, buf_q[`UART_DATA_W-1:1]};
                        bit_d = bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_d = st_stop;
                        end
                    end
                end
            end
            default: begin
                if (tick) begin
                    tick_d = tick_q + 1'b1;
                    if (tick_q == 4'(`UART_OVERSAMPLE - 1)) begin
                        done_d  = 1'b1;
                        state_d = st_idle;
                    end
                end
            end
        endcase
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_done |=> !rx_done);

endmodule

// File: uart_tx.sv
`timescale 1ns/10ps
`include "uart_apb_macros.svh"

module uart_tx
    import uart_apb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       tx_valid,
    input  uart_byte_t tx_data,
    output logic       take,
    output logic       tx
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } tx_state_e;

    tx_state_e  state_q, state_d;
    logic [3:0] tick_q, tick_d;
    logic [2:0] bit_q, bit_d;
    uart_byte_t buf_q, buf_d;
    logic       tx_q, tx_d;

    // pop the fifo head as it is loaded
    assign take = (state_q == st_idle) && tx_valid;
    assign tx   = tx_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_idle;
            tick_q  <= '0;
            bit_q   <= '0;
            tx_q    <= 1'b1;
        end else begin
            state_q <= state_d;
            tick_q  <= tick_d;
            bit_q   <= bit_d;
            tx_q    <= tx_d;
        end
    end

    always_ff @(posedge clk) begin
        buf_q <= buf_d;
    end

    always_comb begin
        state_d = state_q;
        tick_d  = tick_q;
        bit_d   = bit_q;
        buf_d   = buf_q;
        case (state_q)
            st_idle: begin
                if (tx_valid) begin
                    tick_d  = '0;
                    bit_d   = '0;
                    buf_d   = tx_data;
                    state_d = st_start;
                end
            end
            st_start: begin
                if (tick) begin
                    tick_d = tick_q + 1'b1;
                    if (tick_q == 4'(`UART_OVERSAMPLE - 1)) begin
                        state_d = st_data;
                    end
                end
            end
            st_data: begin
                if (tick) begin
                    tick_d = tick_q + 1'b1;
                    if (tick_q == 4'(`UART_OVERSAMPLE - 1)) begin
                        // lsb first
                        buf_d = buf_q >> 1;
                        bit_d = bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_d = st_stop;
                        end
                    end
                end
            end
            default: begin
                if (tick) begin
                    tick_d = tick_q + 1'b1;
                    if (tick_q == 4'(`UART_OVERSAMPLE - 1)) begin
                        state_d = st_idle;
                    end
                end
            end
        endcase
    end

    // line level follows the next state
    always_comb begin
        case (state_d)
            st_start: tx_d = 1'b0;
            st_data:  tx_d = buf_d[0];
            default:  tx_d = 1'b1;
        endcase
    end

endmodule
